// ==== common/usiPkg.sv ====
// USI register bus package with command encoding, bus widths and block address map
`default_nettype none

package usiPkg;

	// ---------------------------------------------------------------------
	// Bus command
	// ---------------------------------------------------------------------
	// Held by the master for exactly one cycle per transaction
	typedef enum logic [1:0]
	{
		cmdIdle  = 2'd0,
		cmdWrite = 2'd1,
		cmdRead  = 2'd2
	} usiCmd;

	// ---------------------------------------------------------------------
	// Bus widths
	// ---------------------------------------------------------------------
	localparam int busAdrsBit   = 16;
	// Upper field picks the block
	localparam int blockAdrsBit = 8;
	// Lower field picks the register inside a block
	localparam int regAdrsBit   = 8;
	localparam int busDataBit   = 32;

	// ---------------------------------------------------------------------
	// Block address map
	// ---------------------------------------------------------------------
	localparam logic [blockAdrsBit-1:0] gpioAdrsMap = 8'h01;
	localparam logic [blockAdrsBit-1:0] pwmAdrsMap  = 8'h02;

	// GPIO register offsets
	localparam logic [regAdrsBit-1:0] gpioLedReg = 8'd0;
	localparam logic [regAdrsBit-1:0] gpioInReg  = 8'd1;

	// PWM register offsets
	localparam logic [regAdrsBit-1:0] pwmPeriodReg = 8'd0;
	localparam logic [regAdrsBit-1:0] pwmDutyReg   = 8'd1;
	localparam logic [regAdrsBit-1:0] pwmEnableReg = 8'd2;

endpackage

`default_nettype wire

// ==== design/usiBus/usiBus.sv ====
// USI bus interconnect decoding the block field and returning registered read data
`timescale 1ns/1ps
`default_nettype none

module usiBus
(
	// Master side
	input  wire                            sysClk,
	input  wire                            reset,
	input  wire usiPkg::usiCmd             cmd,
	input  wire [usiPkg::busAdrsBit-1:0]   adrs,
	input  wire [usiPkg::busDataBit-1:0]   wd,
	output logic [usiPkg::busDataBit-1:0]  rd,
	output logic                           rdValid,
	// GPIO side
	output logic                           gpioSel,
	output usiPkg::usiCmd                  gpioCmd,
	output logic [usiPkg::regAdrsBit-1:0]  regAdrs,
	output logic [usiPkg::busDataBit-1:0]  slvWd,
	input  wire [usiPkg::busDataBit-1:0]   gpioRd,
	input  wire                            gpioRdValid,
	// PWM side
	output logic                           pwmSel,
	output usiPkg::usiCmd                  pwmCmd,
	input  wire [usiPkg::busDataBit-1:0]   pwmRd,
	input  wire                            pwmRdValid
);

logic [usiPkg::blockAdrsBit-1:0] blockCode;
logic                            unmapRd;
logic                            unmapRdDly;
logic [usiPkg::busDataBit-1:0]   rdMux;
logic                            rdValidMux;

// ----------------------------------------------------------------------
// Block decode and command routing
// ----------------------------------------------------------------------
assign blockCode = adrs[usiPkg::busAdrsBit-1 -: usiPkg::blockAdrsBit];
assign regAdrs   = adrs[usiPkg::regAdrsBit-1:0];
// Write data fans out unchanged
assign slvWd     = wd;

assign gpioSel = (blockCode == usiPkg::gpioAdrsMap);
assign pwmSel  = (blockCode == usiPkg::pwmAdrsMap);

// Only the selected slave ever sees a command
assign gpioCmd = gpioSel ? cmd : usiPkg::cmdIdle;
assign pwmCmd  = pwmSel ? cmd : usiPkg::cmdIdle;

// ----------------------------------------------------------------------
// Unmapped reads
// ----------------------------------------------------------------------
// Nobody answers these, so the bus does
assign unmapRd = (cmd == usiPkg::cmdRead) && !gpioSel && !pwmSel;

// One stage to match the slave read register
always_ff @(posedge sysClk)
begin
	if (reset)
	begin
		unmapRdDly <= 1'b0;
	end
	else
	begin
		unmapRdDly <= unmapRd;
	end
end

// ----------------------------------------------------------------------
// Read return
// ----------------------------------------------------------------------
// OR of valid-gated slave data, unmapped contributes zero
assign rdMux      = (gpioRdValid ? gpioRd : '0) | (pwmRdValid ? pwmRd : '0);
assign rdValidMux = gpioRdValid | pwmRdValid | unmapRdDly;

always_ff @(posedge sysClk)
begin
	if (reset)
	begin
		rdValid <= 1'b0;
	end
	else
	begin
		rdValid <= rdValidMux;
	end
end

// Data only matters while rdValid is high
always_ff @(posedge sysClk)
begin
	rd <= rdMux;
end

// ----------------------------------------------------------------------
// Checks
// ----------------------------------------------------------------------
// Slave stage plus return stage
aRdLatency: assert property (@(posedge sysClk) disable iff (reset)
	rdValid |-> $past(cmd == usiPkg::cmdRead, 2))
	else $error("usiBus: rdValid without a read two cycles earlier");

// Responses must never collide in the OR mux
aOneSlaveValid: assert property (@(posedge sysClk) disable iff (reset)
	!(gpioRdValid && pwmRdValid))
	else $error("usiBus: two slaves returned data in one cycle");

aCmdKnown: assert property (@(posedge sysClk) disable iff (reset)
	!$isunknown(cmd))
	else $error("usiBus: unknown command from master");

endmodule

`default_nettype wire

// ==== design/gpioBlock/gpioBlock.sv ====
// GPIO slave holding the LED register and reading back synchronized inputs
`timescale 1ns/1ps
`default_nettype none

module gpioBlock #(
	parameter int pGpioInWidth = 4
)(
	input  wire                            sysClk,
	input  wire                            reset,
	// Bus side
	input  wire                            sel,
	input  wire usiPkg::usiCmd             cmd,
	input  wire [usiPkg::regAdrsBit-1:0]   regAdrs,
	input  wire [usiPkg::busDataBit-1:0]   wd,
	output logic [usiPkg::busDataBit-1:0]  rd,
	output logic                           rdValid,
	// Pins
	input  wire [pGpioInWidth-1:0]         gpioIn,
	output logic [1:0]                     led,
	output logic                           ledR,
	output logic                           ledG,
	output logic                           ledB
);

localparam int ledRegBit = 5;

logic [ledRegBit-1:0]          ledReg;
logic [pGpioInWidth-1:0]       gpioInMeta;
logic [pGpioInWidth-1:0]       gpioInSync;
logic [usiPkg::busDataBit-1:0] rdNext;

// ----------------------------------------------------------------------
// LED register
// ----------------------------------------------------------------------
always_ff @(posedge sysClk)
begin
	if (reset)
	begin
		ledReg <= '0;
	end
	else if (sel && (cmd == usiPkg::cmdWrite) && (regAdrs == usiPkg::gpioLedReg))
	begin
		ledReg <= wd[ledRegBit-1:0];
	end
end

// Bit split onto the board pins
assign led  = ledReg[1:0];
assign ledB = ledReg[2];
assign ledG = ledReg[3];
assign ledR = ledReg[4];

// Two-flop synchronizer for the async inputs
always_ff @(posedge sysClk)
begin
	gpioInMeta <= gpioIn;
	gpioInSync <= gpioInMeta;
end

// ----------------------------------------------------------------------
// Register read
// ----------------------------------------------------------------------
always_comb
begin
	rdNext = '0;
	case (regAdrs)
		usiPkg::gpioLedReg: rdNext[ledRegBit-1:0] = ledReg;
		usiPkg::gpioInReg:  rdNext[pGpioInWidth-1:0] = gpioInSync;
		// Unused offsets read as zero
		default:            rdNext = '0;
	endcase
end

always_ff @(posedge sysClk)
begin
	if (reset)
	begin
		rdValid <= 1'b0;
	end
	else
	begin
		rdValid <= sel && (cmd == usiPkg::cmdRead);
	end
end

always_ff @(posedge sysClk)
begin
	rd <= rdNext;
end

endmodule

`default_nettype wire

// ==== design/pwmBlock/pwmBlock.sv ====
// PWM slave generating the display backlight from period, duty and enable registers
`timescale 1ns/1ps
`default_nettype none

module pwmBlock #(
	parameter int pPwmWidth = 16
)(
	input  wire                            sysClk,
	input  wire                            reset,
	// Bus side
	input  wire                            sel,
	input  wire usiPkg::usiCmd             cmd,
	input  wire [usiPkg::regAdrsBit-1:0]   regAdrs,
	input  wire [usiPkg::busDataBit-1:0]   wd,
	output logic [usiPkg::busDataBit-1:0]  rd,
	output logic                           rdValid,
	// Backlight pin
	output logic                           backLight
);

logic [pPwmWidth-1:0]          periodReg;
logic [pPwmWidth-1:0]          dutyReg;
logic                          enableReg;
logic [pPwmWidth-1:0]          counter;
logic                          wrEn;
logic [usiPkg::busDataBit-1:0] rdNext;

// ----------------------------------------------------------------------
// Control registers
// ----------------------------------------------------------------------
assign wrEn = sel && (cmd == usiPkg::cmdWrite);

always_ff @(posedge sysClk)
begin
	if (reset)
	begin
		periodReg <= '0;
		dutyReg   <= '0;
		enableReg <= 1'b0;
	end
	else if (wrEn)
	begin
		case (regAdrs)
			usiPkg::pwmPeriodReg: periodReg <= wd[pPwmWidth-1:0];
			usiPkg::pwmDutyReg:   dutyReg   <= wd[pPwmWidth-1:0];
			usiPkg::pwmEnableReg: enableReg <= wd[0];
			default:              ;
		endcase
	end
end

// ----------------------------------------------------------------------
// Period counter and output
// ----------------------------------------------------------------------
// Runs 0..period, parked at zero while disabled
always_ff @(posedge sysClk)
begin
	if (reset || !enableReg)
	begin
		counter <= '0;
	end
	// At or above, so a smaller period applies at once
	else if (counter >= periodReg)
	begin
		counter <= '0;
	end
	else
	begin
		counter <= counter + 1'b1;
	end
end

// High for min(duty, period+1) counts per period
always_ff @(posedge sysClk)
begin
	if (reset)
	begin
		backLight <= 1'b0;
	end
	else
	begin
		backLight <= enableReg && (counter < dutyReg);
	end
end

// ----------------------------------------------------------------------
// Register read
// ----------------------------------------------------------------------
always_comb
begin
	rdNext = '0;
	case (regAdrs)
		usiPkg::pwmPeriodReg: rdNext[pPwmWidth-1:0] = periodReg;
		usiPkg::pwmDutyReg:   rdNext[pPwmWidth-1:0] = dutyReg;
		usiPkg::pwmEnableReg: rdNext[0] = enableReg;
		default:              rdNext = '0;
	endcase
end

always_ff @(posedge sysClk)
begin
	if (reset)
	begin
		rdValid <= 1'b0;
	end
	else
	begin
		rdValid <= sel && (cmd == usiPkg::cmdRead);
	end
end

always_ff @(posedge sysClk)
begin
	rd <= rdNext;
end

endmodule

`default_nettype wire

// ==== design/processor.sv ====
// Processor top joining the USI bus with the GPIO and PWM slaves
`timescale 1ns/1ps
`default_nettype none

module processor #(
	parameter int pPwmWidth    = 16,
	parameter int pGpioInWidth = 4
)(
	input  wire                            sysClk,
	input  wire                            reset,
	// Bus master port
	input  wire usiPkg::usiCmd             cmd,
	input  wire [usiPkg::busAdrsBit-1:0]   adrs,
	input  wire [usiPkg::busDataBit-1:0]   wd,
	output logic [usiPkg::busDataBit-1:0]  rd,
	output logic                           rdValid,
	// Board pins
	input  wire [pGpioInWidth-1:0]         gpioIn,
	output logic [1:0]                     led,
	output logic                           ledR,
	output logic                           ledG,
	output logic                           ledB,
	output logic                           backLight
);

// ----------------------------------------------------------------------
// Bus to slave wiring
// ----------------------------------------------------------------------
// Shared by both slaves
logic [usiPkg::regAdrsBit-1:0] regAdrs;
logic [usiPkg::busDataBit-1:0] slvWd;
// GPIO
logic                          gpioSel;
usiPkg::usiCmd                 gpioCmd;
logic [usiPkg::busDataBit-1:0] gpioRd;
logic                          gpioRdValid;
// PWM
logic                          pwmSel;
usiPkg::usiCmd                 pwmCmd;
logic [usiPkg::busDataBit-1:0] pwmRd;
logic                          pwmRdValid;

usiBus u_usiBus (
	.sysClk      (sysClk),
	.reset       (reset),
	.cmd         (cmd),
	.adrs        (adrs),
	.wd          (wd),
	.rd          (rd),
	.rdValid     (rdValid),
	.gpioSel     (gpioSel),
	.gpioCmd     (gpioCmd),
	.regAdrs     (regAdrs),
	.slvWd       (slvWd),
	.gpioRd      (gpioRd),
	.gpioRdValid (gpioRdValid),
	.pwmSel      (pwmSel),
	.pwmCmd      (pwmCmd),
	.pwmRd       (pwmRd),
	.pwmRdValid  (pwmRdValid)
);

// ----------------------------------------------------------------------
// Slaves
// ----------------------------------------------------------------------
gpioBlock #(
	.pGpioInWidth (pGpioInWidth)
) u_gpioBlock (
	.sysClk  (sysClk),
	.reset   (reset),
	.sel     (gpioSel),
	.cmd     (gpioCmd),
	.regAdrs (regAdrs),
	.wd      (slvWd),
	.rd      (gpioRd),
	.rdValid (gpioRdValid),
	.gpioIn  (gpioIn),
	.led     (led),
	.ledR    (ledR),
	.ledG    (ledG),
	.ledB    (ledB)
);

// Display backlight
pwmBlock #(
	.pPwmWidth (pPwmWidth)
) u_pwmBlock (
	.sysClk    (sysClk),
	.reset     (reset),
	.sel       (pwmSel),
	.cmd       (pwmCmd),
	.regAdrs   (regAdrs),
	.wd        (slvWd),
	.rd        (pwmRd),
	.rdValid   (pwmRdValid),
	.backLight (backLight)
);

endmodule

`default_nettype wire

// ==== verification/sysClockGen.sv ====
// Testbench clock source driving sysClk at a fixed period
`timescale 1ns/1ps
`default_nettype none

module sysClockGen #(
	parameter int pPeriod = 100
)(
	output logic sysClk
);

// Starts low, first rising edge half a period in
initial
begin
	sysClk = 1'b0;
	forever
	begin
		#(pPeriod / 2) sysClk = ~sysClk;
	end
end

endmodule

`default_nettype wire

// ==== verification/processorTb.sv ====
// Processor testbench driving the USI master port and checking reads, LEDs and backlight
`timescale 1ns/1ps
`default_nettype none

module processorTb;

localparam int pwmWidth      = 16;
localparam int gpioWidth     = 4;
localparam int resetCycles   = 16;
// About twice the summed test lengths
localparam int timeoutCycles = 4000;

// Register addresses, block code in the upper byte
localparam logic [usiPkg::busAdrsBit-1:0] ledAdrs     = {usiPkg::gpioAdrsMap, usiPkg::gpioLedReg};
localparam logic [usiPkg::busAdrsBit-1:0] gpioInAdrs  = {usiPkg::gpioAdrsMap, usiPkg::gpioInReg};
localparam logic [usiPkg::busAdrsBit-1:0] pwmPerAdrs  = {usiPkg::pwmAdrsMap, usiPkg::pwmPeriodReg};
localparam logic [usiPkg::busAdrsBit-1:0] pwmDutyAdrs = {usiPkg::pwmAdrsMap, usiPkg::pwmDutyReg};
localparam logic [usiPkg::busAdrsBit-1:0] pwmEnAdrs   = {usiPkg::pwmAdrsMap, usiPkg::pwmEnableReg};
localparam logic [usiPkg::busAdrsBit-1:0] gpioUnused  = {usiPkg::gpioAdrsMap, 8'h05};
localparam logic [usiPkg::busAdrsBit-1:0] pwmUnused   = {usiPkg::pwmAdrsMap, 8'h07};
localparam logic [usiPkg::blockAdrsBit-1:0] unmappedBlock = 8'h09;

logic                          sysClk;
logic                          reset;
usiPkg::usiCmd                 cmd;
logic [usiPkg::busAdrsBit-1:0] adrs;
logic [usiPkg::busDataBit-1:0] wd;
logic [gpioWidth-1:0]          gpioIn;
logic [usiPkg::busDataBit-1:0] rd;
logic                          rdValid;
logic [1:0]                    led;
logic                          ledR;
logic                          ledG;
logic                          ledB;
logic                          backLight;

// Scoreboard and reference state
logic [31:0] expQ [$];
logic [31:0] lcgState = 32'h9936;
logic        cmdSeen = 1'b0;
logic [4:0]  ledWritten = '0;
logic [4:0]  ledPins;
logic        enShadow;
int          readsIssued = 0;
int          readsAnswered = 0;
int          cycleCount = 0;

sysClockGen #(
	.pPeriod (100)
) u_sysClockGen (
	.sysClk (sysClk)
);

processor #(
	.pPwmWidth    (pwmWidth),
	.pGpioInWidth (gpioWidth)
) u_processor (
	.sysClk    (sysClk),
	.reset     (reset),
	.cmd       (cmd),
	.adrs      (adrs),
	.wd        (wd),
	.rd        (rd),
	.rdValid   (rdValid),
	.gpioIn    (gpioIn),
	.led       (led),
	.ledR      (ledR),
	.ledG      (ledG),
	.ledB      (ledB),
	.backLight (backLight)
);

// ----------------------------------------------------------------------
// Error reporting and random source
// ----------------------------------------------------------------------
task automatic failValue(input string name, input logic [31:0] expVal, input logic [31:0] actVal);
	$display("Fail at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
	$display("TEST FAILED");
	$fatal(1, "stopped at first error");
endtask

task automatic failText(input string msg);
	$display("Error at %0t ns: %s", $time, msg);
	$display("TEST FAILED");
	$fatal(1, "stopped at first error");
endtask

// LCG step with a fold of the high half into the weak low bits
function logic [31:0] nextRand();
	lcgState = lcgState * 32'd1664525 + 32'd1013904223;
	return lcgState ^ (lcgState >> 16);
endfunction

// ----------------------------------------------------------------------
// Bus master tasks
// ----------------------------------------------------------------------
// One command for one cycle, driven after the rising edge
task automatic busIssue(input usiPkg::usiCmd c, input logic [15:0] a, input logic [31:0] d);
	@(posedge sysClk);
	cmd     <= c;
	adrs    <= a;
	wd      <= d;
	cmdSeen = 1'b1;
endtask

task automatic busIdle(input int n);
	repeat (n)
	begin
		@(posedge sysClk);
		cmd <= usiPkg::cmdIdle;
	end
endtask

task automatic busWrite(input logic [15:0] a, input logic [31:0] d);
	busIssue(usiPkg::cmdWrite, a, d);
	if (a == ledAdrs)
		ledWritten = d[4:0];
endtask

// Expected response joins the in-order queue
task automatic busRead(input logic [15:0] a, input logic [31:0] expVal);
	busIssue(usiPkg::cmdRead, a, 32'd0);
	expQ.push_back(expVal);
	readsIssued++;
endtask

// ----------------------------------------------------------------------
// Reference shadows and checks
// ----------------------------------------------------------------------
// Writes land at the sampling edge, same as the slave registers
always @(posedge sysClk)
begin
	if (reset)
	begin
		ledPins  <= '0;
		enShadow <= 1'b0;
	end
	else if (cmd == usiPkg::cmdWrite)
	begin
		if (adrs == ledAdrs)
			ledPins <= wd[4:0];
		if (adrs == pwmEnAdrs)
			enShadow <= wd[0];
	end
end

// Outputs sampled mid-cycle
always @(negedge sysClk)
begin
	logic [31:0] expVal;
	if (!reset)
	begin
		if (!cmdSeen)
		begin
			assert ({rdValid, backLight, ledR, ledG, ledB, led} == 7'd0)
			else failValue("outputs after reset", 32'd0,
				32'({rdValid, backLight, ledR, ledG, ledB, led}));
		end
		assert ({ledR, ledG, ledB, led} == ledPins)
		else failValue("{ledR,ledG,ledB,led}", 32'(ledPins), 32'({ledR, ledG, ledB, led}));
		if (rdValid)
		begin
			readsAnswered++;
			if (expQ.size() == 0)
				failText("read response arrived with no read outstanding");
			else
			begin
				expVal = expQ.pop_front();
				assert (rd == expVal)
				else failValue("rd", expVal, rd);
			end
		end
	end
end

// Fixed two-cycle read latency, both directions
aReadLatency: assert property (@(posedge sysClk) disable iff (reset)
	$past(cmd == usiPkg::cmdRead, 2) |-> rdValid)
	else failText("no rdValid two cycles after a read");

aNoStrayValid: assert property (@(posedge sysClk) disable iff (reset)
	rdValid |-> $past(cmd == usiPkg::cmdRead, 2))
	else failText("rdValid without a read two cycles earlier");

aBackLightOff: assert property (@(posedge sysClk) disable iff (reset)
	!$past(enShadow) |-> !backLight)
	else failValue("backLight", 32'd0, 32'($sampled(backLight)));

// Run limit
always @(posedge sysClk)
begin
	cycleCount <= cycleCount + 1;
	if (cycleCount >= timeoutCycles)
		failText($sformatf("run timed out after %0d cycles", timeoutCycles));
end

// ----------------------------------------------------------------------
// Stimulus
// ----------------------------------------------------------------------
initial
begin
	logic [31:0] r;
	logic [31:0] expVal;
	logic [31:0] periodWritten;
	int          period;
	int          duty;
	int          highCount;
	int          highExpect;
	cmd    <= usiPkg::cmdIdle;
	adrs   <= '0;
	wd     <= '0;
	gpioIn <= '0;
	reset  <= 1'b1;
	repeat (resetCycles) @(posedge sysClk);
	reset <= 1'b0;
	// Quiet stretch for the reset-state check
	busIdle(8);

	// LED register write and readback
	repeat (20)
	begin
		busWrite(ledAdrs, nextRand());
		busIdle(1);
		busRead(ledAdrs, 32'(ledWritten));
		busIdle(1);
	end

	// GPIO inputs, read two cycles after each change
	repeat (20)
	begin
		r = nextRand();
		@(posedge sysClk);
		cmd    <= usiPkg::cmdIdle;
		gpioIn <= r[gpioWidth-1:0];
		busIdle(1);
		expVal = '0;
		expVal[gpioWidth-1:0] = r[gpioWidth-1:0];
		busRead(gpioInAdrs, expVal);
		busIdle(2);
	end

	// Back-to-back reads across blocks, unmapped and unused offsets
	r = nextRand();
	periodWritten = 32'(r[pwmWidth-1:0]);
	busWrite(pwmPerAdrs, periodWritten);
	for (int i = 0; i < 40; i++)
	begin
		r = nextRand();
		case (i % 4)
			0:       busRead(ledAdrs, 32'(ledWritten));
			1:       busRead(pwmPerAdrs, periodWritten);
			2:       busRead({unmappedBlock, r[7:0]}, 32'd0);
			default: busRead(r[0] ? gpioUnused : pwmUnused, 32'd0);
		endcase
	end
	busIdle(4);

	// PWM duty count over one full period
	repeat (4)
	begin
		r = nextRand();
		period = 8 + int'(r % 32'd256);
		r = nextRand();
		duty = int'(r % 32'(period + 4));
		busWrite(pwmPerAdrs, 32'(period));
		busWrite(pwmDutyAdrs, 32'(duty));
		busWrite(pwmEnAdrs, 32'd1);
		// Counter settles into whole periods
		busIdle(period + 4);
		highCount = 0;
		repeat (period + 1)
		begin
			@(negedge sysClk);
			if (backLight)
				highCount++;
		end
		highExpect = (duty < period + 1) ? duty : period + 1;
		assert (highCount == highExpect)
		else failValue("backLight high count", 32'(highExpect), 32'(highCount));
		busRead(pwmPerAdrs, 32'(period));
		busRead(pwmDutyAdrs, 32'(duty));
		// Disabled stretch, watched by aBackLightOff
		busWrite(pwmEnAdrs, 32'd0);
		busIdle(period + 4);
	end

	// Last responses drain in two cycles
	busIdle(4);
	if (readsAnswered != readsIssued)
		failValue("read responses", 32'(readsIssued), 32'(readsAnswered));
	else
	begin
		$display("TEST PASSED");
		$finish;
	end
end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/usiPkg.sv
design/usiBus/usiBus.sv
design/gpioBlock/gpioBlock.sv
design/pwmBlock/pwmBlock.sv
design/processor.sv
verification/sysClockGen.sv
verification/processorTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= processorTb
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJDIR)
